/* all.f */
verilog/exec_pkg.sv
verilog/alu_core.sv
verilog/shift_unit.sv
verilog/exec_lane.sv
verilog/issue_dispatch.sv
verilog/retire_reorder.sv
verilog/exec_cluster.sv
tests/clock_gen.sv
tests/exec_cluster_assertions.sv
tests/exec_cluster_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the execute cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
	--top-module exec_cluster_tb -Mdir obj_dir -o sim_exec_cluster
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_exec_cluster)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** TEST PASSED ***'; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* tests/clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module clock_gen #(
	parameter int HALF_PERIOD  = 10,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 rst_n = 1'b1; // Released just after an edge
	end

endmodule

`default_nettype wire

/* tests/exec_cluster_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_cluster_assertions #(
	parameter int NUM_LANES = 4
) (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 in_valid,
	input logic                 busy,
	input logic                 out_valid,
	input logic [NUM_LANES-1:0] lane_start
);

	// Synchronous reset clears the reorder buffer on the next edge
	out_quiet_in_reset: assert property (@(posedge clk) !rst_n |=> !out_valid)
		else $error("out_valid high during reset");

	no_issue_when_busy: assert property (@(posedge clk) disable iff (!rst_n) busy |-> !in_valid)
		else $error("in_valid while busy");

	single_lane_start: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(lane_start))
		else $error("more than one lane_start bit high");

endmodule

bind exec_cluster exec_cluster_assertions #(.NUM_LANES(NUM_LANES)) assertions_i (
	.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .busy(busy),
	.out_valid(out_valid), .lane_start(lane_start)
);

`default_nettype wire

/* tests/exec_cluster_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_cluster_tb;

	localparam int NUM_LANES = 4;
	localparam int NUM_VEC   = 26;
	localparam int NUM_RAND  = 200;
	localparam int NUM_OPC   = 26;
	localparam int WATCH_NS  = (NUM_VEC + NUM_RAND) * 24 * 20 + 16 * 20;
	localparam int DRAIN_CYC = NUM_LANES * 24; // Longest wait for the last results

	typedef struct packed {
		exec_pkg::word_t   opn;
		exec_pkg::word_t   op1;
		exec_pkg::word_t   op2;
		exec_pkg::result_t exp;
	} vector_t;

	logic              clk;
	logic              rst_n;
	logic              in_valid;
	exec_pkg::word_t   in_opn;
	exec_pkg::word_t   in_op1;
	exec_pkg::word_t   in_op2;
	logic              busy;
	logic              out_valid;
	exec_pkg::result_t out_result;

	exec_pkg::result_t expected_q [$];
	int                in_flight = 0; // Model of the outstanding count
	logic              saw_busy = 1'b0;

	////////////////////
	// Directed table
	////////////////////

	// Each row holds opn, op1, op2 and the expected res and flag
	vector_t vectors [NUM_VEC] = '{
		{16'h4800, 16'h1234, 16'h0011, 16'h1245, 1'b0}, // ADDIU
		{16'h4000, 16'hFFFF, 16'h0001, 16'h0000, 1'b1}, // ADDIU3 carry out
		{16'h6300, 16'h8000, 16'h8000, 16'h0000, 1'b1}, // ADDSP
		{16'hE001, 16'h7FFF, 16'h0001, 16'h8000, 1'b0}, // ADDU
		{16'h9800, 16'h0100, 16'h0020, 16'h0120, 1'b0}, // LW
		{16'hD000, 16'hFFF0, 16'h0020, 16'h0010, 1'b1}, // SW_SP
		{16'hE003, 16'h0000, 16'h0001, 16'hFFFF, 1'b1}, // SUBU borrow
		{16'hE003, 16'h0005, 16'h0003, 16'h0002, 1'b0},
		{16'hE80C, 16'hF0F0, 16'h3C3C, 16'h3030, 1'b0}, // AND
		{16'hE80D, 16'hF0F0, 16'h0F01, 16'hFFF1, 1'b0}, // OR
		{16'hE80A, 16'h1234, 16'h1234, 16'h0000, 1'b0}, // CMP equal
		{16'hE80A, 16'h1234, 16'h1235, 16'h0001, 1'b0},
		{16'h7800, 16'hBEEF, 16'h1111, 16'hBEEF, 1'b0}, // MOVE
		{16'hE840, 16'h00A5, 16'h0000, 16'h00A5, 1'b0}, // MFPC
		{16'hF000, 16'h4321, 16'hFFFF, 16'h4321, 1'b0}, // MFIH
		{16'h6400, 16'h5A5A, 16'h0001, 16'h5A5A, 1'b0}, // MTSP
		{16'h0800, 16'hFFFF, 16'hFFFF, 16'h0000, 1'b0}, // NOP
		{16'h1000, 16'h1234, 16'h0001, 16'h0000, 1'b0}, // B
		{16'h3000, 16'h0181, 16'h0000, 16'h8100, 1'b1}, // SLL by 8 shifts bit 8 out
		{16'h3002, 16'h8000, 16'h0003, 16'h1000, 1'b0}, // SRL
		{16'h3003, 16'h8000, 16'h0000, 16'hFF80, 1'b0}, // SRA by 8
		{16'hE807, 16'h0014, 16'h8F00, 16'hF8F0, 1'b0}, // SRAV by 4
		{16'h3000, 16'h0001, 16'h000F, 16'h8000, 1'b0}, // Long shift first
		{16'hE001, 16'h0001, 16'h0002, 16'h0003, 1'b0},
		{16'h4800, 16'h0010, 16'h0001, 16'h0011, 1'b0},
		{16'h4000, 16'h00FF, 16'h0001, 16'h0100, 1'b0}
	};

	exec_pkg::word_t opcodes [NUM_OPC] = '{
		16'h4800, 16'h4000, 16'h6300, 16'hE001, 16'h9000, 16'h9800, 16'hD000,
		16'hD800, 16'hE003, 16'hE80C, 16'hE80D, 16'hE80A, 16'h6400, 16'hE840,
		16'h6800, 16'hF000, 16'hF001, 16'h7800, 16'h0800, 16'h1000, 16'h6000,
		16'hE800, 16'h3000, 16'h3002, 16'h3003, 16'hE807
	};

	clock_gen clock_i (.clk(clk), .rst_n(rst_n));

	exec_cluster #(.NUM_LANES(NUM_LANES)) dut_i (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_opn(in_opn),
		.in_op1(in_op1), .in_op2(in_op2), .busy(busy),
		.out_valid(out_valid), .out_result(out_result)
	);

	////////////////////
	// Helpers
	////////////////////

	task automatic abort_run();
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_result(input exec_pkg::result_t got, input exec_pkg::result_t exp);
		if (got !== exp) begin
			$display("FAILED out_result got res=%h flag=%h expected res=%h flag=%h",
				got.res, got.flag, exp.res, exp.flag);
			abort_run();
		end
	endtask

	task automatic check_busy(input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED busy got %h expected %h", got, exp);
			abort_run();
		end
	endtask

	// Expected result of one instruction from the opcode rules
	function automatic exec_pkg::result_t model_result(input exec_pkg::word_t opn,
		input exec_pkg::word_t op1, input exec_pkg::word_t op2);
		logic [32:0] wide;
		int          n;
		model_result = '0;
		n = (op2[4:0] == 5'd0) ? 8 : int'(op2[4:0]); // Zero means eight
		case (opn)
			16'h4800, 16'h4000, 16'h6300, 16'hE001,
			16'h9000, 16'h9800, 16'hD000, 16'hD800: begin
				{model_result.flag, model_result.res} = {1'b0, op1} + {1'b0, op2};
			end
			16'hE003: {model_result.flag, model_result.res} = {1'b0, op1} - {1'b0, op2};
			16'hE80C: model_result.res = op1 & op2;
			16'hE80D: model_result.res = op1 | op2;
			16'hE80A: model_result.res = (op1 != op2) ? 16'h0001 : 16'h0000;
			16'h6400, 16'hE840, 16'h6800, 16'hF000, 16'hF001, 16'h7800: begin
				model_result.res = op1;
			end
			16'h3000: begin
				wide = {17'b0, op1} << n; // Bit 16 is the last bit out
				model_result.res  = wide[15:0];
				model_result.flag = wide[16];
			end
			16'h3002: model_result.res = op1 >> n;
			16'h3003: model_result.res = $signed(op1) >>> n;
			16'hE807: model_result.res = $signed(op2) >>> op1[3:0];
			default: begin
			end
		endcase
	endfunction

	// Called and returns 2 ns after a rising edge
	task automatic issue_instr(input exec_pkg::word_t opn, input exec_pkg::word_t op1,
		input exec_pkg::word_t op2, input exec_pkg::result_t exp);
		while (busy) begin
			@(posedge clk);
			#2;
		end
		in_valid = 1'b1;
		in_opn   = opn;
		in_op1   = op1;
		in_op2   = op2;
		expected_q.push_back(exp);
		@(posedge clk);
		#2;
		in_valid = 1'b0;
	endtask

	////////////////////
	// Monitor and watchdog
	////////////////////

	always @(negedge clk) begin
		if (rst_n) begin
			check_busy(busy, in_flight == NUM_LANES);
			if (busy) begin
				saw_busy = 1'b1;
			end
			if (out_valid) begin
				if (expected_q.size() == 0) begin
					$display("A result left the cluster with no instruction pending");
					abort_run();
				end else begin
					check_result(out_result, expected_q.pop_front());
				end
			end
			in_flight = in_flight + int'(in_valid) - int'(out_valid);
		end
	end

	initial begin
		#WATCH_NS;
		$display("Timeout after %0d ns, the cluster stopped producing results", WATCH_NS);
		abort_run();
	end

	initial begin
		exec_pkg::word_t opn;
		exec_pkg::word_t a;
		exec_pkg::word_t b;
		int              gap;
		int              drain;
		in_valid = 1'b0;
		in_opn   = '0;
		in_op1   = '0;
		in_op2   = '0;
		void'($urandom(32'h3ba7_ff58));
		@(posedge rst_n);
		@(posedge clk);
		#2;
		for (int i = 0; i < NUM_VEC; i++) begin
			issue_instr(vectors[i].opn, vectors[i].op1, vectors[i].op2, vectors[i].exp);
		end
		for (int i = 0; i < NUM_RAND; i++) begin
			opn = opcodes[$urandom_range(0, NUM_OPC - 1)];
			a   = exec_pkg::word_t'($urandom());
			b   = exec_pkg::word_t'($urandom());
			if (opn == 16'h3000 || opn == 16'h3002 || opn == 16'h3003) begin
				b = b & 16'h0007; // 3-bit shift immediate
			end
			issue_instr(opn, a, b, model_result(opn, a, b));
			gap = $urandom_range(0, 3);
			repeat (gap) begin
				@(posedge clk);
				#2;
			end
		end
		drain = 0;
		while (expected_q.size() != 0 && drain < DRAIN_CYC) begin
			@(posedge clk);
			drain++;
		end
		repeat (8) @(posedge clk); // Catch any duplicate result
		if (expected_q.size() != 0) begin
			$display("Expected results were left unconsumed");
			abort_run();
		end else if (!saw_busy) begin
			$display("busy never rose with all lanes occupied");
			abort_run();
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* verilog/alu_core.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_core (
	input  exec_pkg::word_t opn,
	input  exec_pkg::word_t op1,
	input  exec_pkg::word_t op2,
	output exec_pkg::word_t res,
	output logic            flag
);

	logic [exec_pkg::WORD_W:0] sum; // Carry out in the top bit
	logic [exec_pkg::WORD_W:0] diff; // Borrow in the top bit
	logic                      ne;

	assign sum  = {1'b0, op1} + {1'b0, op2};
	assign diff = {1'b0, op1} - {1'b0, op2};
	assign ne   = (op1 != op2);

	always_comb begin
		res  = '0; // Branches, jumps, NOP and shifts
		flag = 1'b0;
		case (opn[15:11])
			exec_pkg::OPC_ADDIU,
			exec_pkg::OPC_ADDIU3,
			exec_pkg::OPC_LW,
			exec_pkg::OPC_LW_SP,
			exec_pkg::OPC_SW,
			exec_pkg::OPC_SW_SP: begin
				{flag, res} = sum; // Address or immediate add
			end
			exec_pkg::OPC_SP: begin
				if (opn[10:8] == 3'b011) begin // ADDSP
					{flag, res} = sum;
				end else if (opn[10:8] == 3'b100 && opn[4:0] == 5'b00000) begin
					res = op1; // MTSP
				end
			end
			exec_pkg::OPC_RRR: begin
				if (opn[1:0] == 2'b01) begin // ADDU
					{flag, res} = sum;
				end else begin // SUBU
					{flag, res} = diff;
				end
			end
			exec_pkg::OPC_RR: begin
				if (opn[4:0] == 5'b01100) begin // AND
					res = op1 & op2;
				end else if (opn[4:0] == 5'b01101) begin // OR
					res = op1 | op2;
				end else if (opn[4:0] == 5'b01010) begin // CMP
					res = {{(exec_pkg::WORD_W-1){1'b0}}, ne};
				end else if (opn[7:0] == 8'b0100_0000) begin // MFPC
					res = op1;
				end
				// JR, JALR and JRRA stay zero, SRAV goes to the shifter
			end
			exec_pkg::OPC_LI: begin
				res = op1;
			end
			exec_pkg::OPC_IH: begin
				if (opn[7:0] == 8'b0000_0000) begin // MFIH
					res = op1;
				end else if (opn[4:0] == 5'b00001) begin // MTIH
					res = op1;
				end
			end
			exec_pkg::OPC_MOVE: begin
				if (opn[4:0] == 5'b00000) begin
					res = op1;
				end
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

/* verilog/exec_cluster.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_cluster #(
	parameter int NUM_LANES = 4
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  exec_pkg::word_t   in_opn,
	input  exec_pkg::word_t   in_op1,
	input  exec_pkg::word_t   in_op2,
	output logic              busy,
	output logic              out_valid,
	output exec_pkg::result_t out_result
);

	logic [NUM_LANES-1:0] lane_start;
	logic [NUM_LANES-1:0] lane_idle;
	logic [NUM_LANES-1:0] lane_done;
	exec_pkg::exec_req_t  lane_req; // Shared, qualified by lane_start
	exec_pkg::exec_res_t  lane_result [NUM_LANES];
	logic                 retire;

	issue_dispatch #(.NUM_LANES(NUM_LANES)) dispatch_i (
		.clk(clk), .rst_n(rst_n), .in_valid(in_valid),
		.in_opn(in_opn), .in_op1(in_op1), .in_op2(in_op2),
		.lane_idle(lane_idle), .retire(retire),
		.lane_start(lane_start), .lane_req(lane_req), .busy(busy)
	);

	for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
		exec_lane lane_i (
			.clk(clk), .rst_n(rst_n), .start(lane_start[g]), .req(lane_req),
			.idle(lane_idle[g]), .done(lane_done[g]), .result(lane_result[g])
		);
	end

	retire_reorder #(.NUM_LANES(NUM_LANES)) reorder_i (
		.clk(clk), .rst_n(rst_n), .lane_done(lane_done), .lane_result(lane_result),
		.out_valid(out_valid), .out_result(out_result), .retire(retire)
	);

endmodule

`default_nettype wire

/* verilog/exec_lane.sv */
`timescale 1ns/100ps
`default_nettype none

module exec_lane (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  exec_pkg::exec_req_t req,
	output logic                idle,
	output logic                done,
	output exec_pkg::exec_res_t result
);

	exec_pkg::opc_t  major;
	logic            is_srav;
	logic            is_shift;
	exec_pkg::word_t sh_value;
	logic [4:0]      sh_amount;
	logic [1:0]      sh_kind;
	exec_pkg::word_t sh_res;
	logic            sh_flag;
	logic            sh_done;
	exec_pkg::word_t core_res;
	logic            core_flag;
	logic            held_q; // Instruction in the lane
	logic            core_pend_q;
	exec_pkg::tag_t  tag_q;
	exec_pkg::word_t core_res_q;
	logic            core_flag_q;

	assign major    = req.opn[15:11];
	assign is_srav  = (major == exec_pkg::OPC_RR) && (req.opn[4:0] == 5'b00111);
	assign is_shift = is_srav || ((major == exec_pkg::OPC_SHIFT) && (req.opn[1:0] != 2'b01));

	always_comb begin
		if (is_srav) begin
			sh_value  = req.op2;
			sh_amount = {1'b0, req.op1[3:0]};
			sh_kind   = exec_pkg::SH_RA;
		end else begin
			sh_value  = req.op1;
			sh_amount = (req.op2[4:0] == 5'd0) ? 5'd8 : req.op2[4:0]; // Zero means eight
			case (req.opn[1:0])
				2'b00:   sh_kind = exec_pkg::SH_LL;
				2'b11:   sh_kind = exec_pkg::SH_RA;
				default: sh_kind = exec_pkg::SH_RL;
			endcase
		end
	end

	alu_core core_i (.opn(req.opn), .op1(req.op1), .op2(req.op2), .res(core_res), .flag(core_flag));

	shift_unit shift_i (
		.clk(clk), .rst_n(rst_n), .start(start && is_shift), .value(sh_value),
		.amount(sh_amount), .kind(sh_kind), .done(sh_done), .res(sh_res), .flag(sh_flag)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			held_q      <= 1'b0;
			core_pend_q <= 1'b0;
		end else begin
			core_pend_q <= start && !is_shift; // Core result ready next cycle
			if (start) begin
				held_q <= 1'b1;
			end else if (done) begin
				held_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			tag_q       <= req.tag;
			core_res_q  <= core_res;
			core_flag_q <= core_flag;
		end
	end

	assign idle        = !held_q;
	assign done        = core_pend_q || sh_done;
	assign result.tag  = tag_q;
	assign result.res  = core_pend_q ? core_res_q : sh_res;
	assign result.flag = core_pend_q ? core_flag_q : sh_flag;

endmodule

`default_nettype wire

/* verilog/exec_pkg.sv */
`default_nettype none

package exec_pkg;

	////////////////////
	// Words and tags
	////////////////////

	localparam int WORD_W = 16;
	localparam int TAG_W  = 4; // 16 reorder entries

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [TAG_W-1:0]  tag_t;
	typedef logic [4:0]        opc_t; // Primary field, opn[15:11]

	////////////////////
	// Primary opcodes
	////////////////////

	localparam opc_t OPC_SHIFT  = 5'b00110; // SLL, SRL, SRA
	localparam opc_t OPC_ADDIU3 = 5'b01000;
	localparam opc_t OPC_ADDIU  = 5'b01001;
	localparam opc_t OPC_SP     = 5'b01100; // ADDSP, MTSP, BTEQZ
	localparam opc_t OPC_LI     = 5'b01101;
	localparam opc_t OPC_MOVE   = 5'b01111;
	localparam opc_t OPC_LW_SP  = 5'b10010;
	localparam opc_t OPC_LW     = 5'b10011;
	localparam opc_t OPC_SW_SP  = 5'b11010;
	localparam opc_t OPC_SW     = 5'b11011;
	localparam opc_t OPC_RRR    = 5'b11100; // ADDU, SUBU
	localparam opc_t OPC_RR     = 5'b11101; // AND, OR, CMP, MFPC, SRAV, jumps
	localparam opc_t OPC_IH     = 5'b11110; // MFIH, MTIH

	// Shift unit kind codes
	localparam logic [1:0] SH_LL = 2'b00;
	localparam logic [1:0] SH_RL = 2'b01;
	localparam logic [1:0] SH_RA = 2'b10;

	////////////////////
	// Payloads
	////////////////////

	typedef struct packed {
		tag_t  tag;
		word_t opn;
		word_t op1;
		word_t op2;
	} exec_req_t; // 52 bits

	typedef struct packed {
		tag_t  tag;
		word_t res;
		logic  flag;
	} exec_res_t; // 21 bits

	typedef struct packed {
		word_t res;
		logic  flag;
	} result_t; // 17 bits

endpackage

`default_nettype wire

/* verilog/issue_dispatch.sv */
`timescale 1ns/100ps
`default_nettype none

module issue_dispatch #(
	parameter int NUM_LANES = 4
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid,
	input  exec_pkg::word_t      in_opn,
	input  exec_pkg::word_t      in_op1,
	input  exec_pkg::word_t      in_op2,
	input  logic [NUM_LANES-1:0] lane_idle,
	input  logic                 retire,
	output logic [NUM_LANES-1:0] lane_start,
	output exec_pkg::exec_req_t  lane_req,
	output logic                 busy
);

	localparam int CNT_W = $clog2(NUM_LANES + 1);

	logic [NUM_LANES-1:0] free;
	logic [NUM_LANES-1:0] pick;
	exec_pkg::tag_t       next_tag_q;
	logic [CNT_W-1:0]     outstanding_q; // Accepted and not yet retired

	// A lane started this cycle still shows idle
	assign free = lane_idle & ~lane_start;
	assign pick = free & (~free + 1'b1); // Lowest free lane

	assign busy = (outstanding_q == CNT_W'(NUM_LANES));

	////////////////////
	// Control
	////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lane_start    <= '0;
			next_tag_q    <= '0;
			outstanding_q <= '0;
		end else begin
			lane_start <= in_valid ? pick : '0;
			if (in_valid) begin
				next_tag_q <= next_tag_q + 1'b1;
			end
			case ({in_valid, retire})
				2'b10:   outstanding_q <= outstanding_q + 1'b1;
				2'b01:   outstanding_q <= outstanding_q - 1'b1;
				default: outstanding_q <= outstanding_q;
			endcase
		end
	end

	// One request word shared by all lanes
	always_ff @(posedge clk) begin
		if (in_valid) begin
			lane_req.tag <= next_tag_q;
			lane_req.opn <= in_opn;
			lane_req.op1 <= in_op1;
			lane_req.op2 <= in_op2;
		end
	end

endmodule

`default_nettype wire

/* verilog/retire_reorder.sv */
`timescale 1ns/100ps
`default_nettype none

module retire_reorder #(
	parameter int NUM_LANES = 4
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [NUM_LANES-1:0] lane_done,
	input  exec_pkg::exec_res_t  lane_result [NUM_LANES],
	output logic                 out_valid,
	output exec_pkg::result_t    out_result,
	output logic                 retire
);

	localparam int DEPTH = 2 ** exec_pkg::TAG_W;

	exec_pkg::result_t rob_mem [DEPTH];
	logic [DEPTH-1:0]  present_q; // One bit per tag
	exec_pkg::tag_t    head_q; // Oldest tag in flight

	assign out_valid  = present_q[head_q];
	assign out_result = rob_mem[head_q];
	assign retire     = out_valid;

	////////////////////
	// Result storage
	////////////////////

	// Tags in flight are distinct, so parallel writes never collide
	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_LANES; i++) begin
			if (lane_done[i]) begin
				rob_mem[lane_result[i].tag] <= '{res: lane_result[i].res, flag: lane_result[i].flag};
			end
		end
	end

	////////////////////
	// Head and present bits
	////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			present_q <= '0;
			head_q    <= '0;
		end else begin
			if (out_valid) begin
				present_q[head_q] <= 1'b0; // Entry leaves this cycle
				head_q            <= head_q + 1'b1;
			end
			for (int i = 0; i < NUM_LANES; i++) begin
				if (lane_done[i]) begin
					present_q[lane_result[i].tag] <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/shift_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module shift_unit (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            start,
	input  exec_pkg::word_t value,
	input  logic [4:0]      amount,
	input  logic [1:0]      kind,
	output logic            done,
	output exec_pkg::word_t res,
	output logic            flag
);

	logic            active_q;
	logic [4:0]      count_q; // Bits still to shift
	logic [1:0]      kind_q;
	exec_pkg::word_t data_q;
	logic            flag_q; // Last bit out on the left

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active_q <= 1'b0;
			count_q  <= '0;
			kind_q   <= exec_pkg::SH_LL;
		end else if (start) begin
			active_q <= 1'b1;
			count_q  <= amount;
			kind_q   <= kind;
		end else if (active_q) begin
			if (count_q == '0) begin
				active_q <= 1'b0; // Result taken this cycle
			end else begin
				count_q <= count_q - 5'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			data_q <= value;
			flag_q <= 1'b0;
		end else if (active_q && count_q != '0) begin
			case (kind_q)
				exec_pkg::SH_LL: {flag_q, data_q} <= {data_q, 1'b0};
				exec_pkg::SH_RL: data_q <= {1'b0, data_q[exec_pkg::WORD_W-1:1]};
				exec_pkg::SH_RA: data_q <= {data_q[exec_pkg::WORD_W-1], data_q[exec_pkg::WORD_W-1:1]};
				default: data_q <= data_q;
			endcase
		end
	end

	assign done = active_q && (count_q == '0);
	assign res  = data_q;
	assign flag = flag_q;

endmodule

`default_nettype wire
